// ==== design/ecc_mem_pkg.sv ====
// ECC memory shared definitions
`default_nettype none

package ecc_mem_pkg;

  // data word and SECDED codeword geometry
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ECC_W  = 7;
  localparam int unsigned CODE_W = DATA_W + ECC_W;

  // hsiao check matrix, one row per check bit
  // every data column has weight three, 32 of the 35 such patterns
  // check bit columns are the unit vectors, so no data column aliases them
  localparam logic [DATA_W-1:0] PARITY_MASK [ECC_W] = '{
    32'h0000_7FFF,
    32'h01FF_801F,
    32'h7E07_81E1,
    32'h8E38_8E22,
    32'hB2C9_3244,
    32'hD552_5488,
    32'h69A4_6910
  };

  // decoder verdict, code 2'b11 is never produced
  typedef enum logic [1:0] {
    ERR_NONE   = 2'b00,
    ERR_SINGLE = 2'b01,
    ERR_DOUBLE = 2'b10
  } ecc_err_e;

endpackage

`default_nettype wire

// ==== design/secded_39_32_enc.sv ====
// SECDED 39/32 encoder
`timescale 1ns/1ps
`default_nettype none

module secded_39_32_enc (
  input  logic [ecc_mem_pkg::DATA_W-1:0] data_i,
  output logic [ecc_mem_pkg::CODE_W-1:0] code_o
);

  import ecc_mem_pkg::*;

  logic [ECC_W-1:0] check;

  // each check bit is the parity over its row of the matrix
  always_comb begin
    for (int j = 0; j < ECC_W; j++) begin
      check[j] = ^(data_i & PARITY_MASK[j]);
    end
  end

  // systematic code, data keeps its position in the low bits
  // check bits ride above it
  assign code_o = {check, data_i};

endmodule

`default_nettype wire

// ==== design/secded_39_32_dec.sv ====
// SECDED 39/32 decoder
`timescale 1ns/1ps
`default_nettype none

module secded_39_32_dec (
  input  logic [ecc_mem_pkg::CODE_W-1:0] code_i,
  output logic [ecc_mem_pkg::DATA_W-1:0] data_o,
  output logic [ecc_mem_pkg::ECC_W-1:0]  syndrome_o,
  output ecc_mem_pkg::ecc_err_e          err_o
);

  import ecc_mem_pkg::*;

  logic [DATA_W-1:0] rx_data;
  logic [ECC_W-1:0]  rx_check;
  logic [ECC_W-1:0]  syndrome;
  logic [DATA_W-1:0] flip;
  logic              odd_weight;

  // split the received word
  assign rx_data  = code_i[DATA_W-1:0];
  assign rx_check = code_i[CODE_W-1:DATA_W];

  // recomputed parity against the stored check bits
  always_comb begin
    for (int j = 0; j < ECC_W; j++) begin
      syndrome[j] = (^(rx_data & PARITY_MASK[j])) ^ rx_check[j];
    end
  end

  // hsiao columns are odd, so a lone flip gives an odd syndrome
  assign odd_weight = ^syndrome;

  // locate the data column equal to the syndrome
  always_comb begin
    logic [ECC_W-1:0] col;
    col = '0;
    for (int i = 0; i < DATA_W; i++) begin
      for (int j = 0; j < ECC_W; j++) begin
        col[j] = PARITY_MASK[j][i];
      end
      flip[i] = (col == syndrome);
    end
  end

  // only correct on a single error
  // a check bit hit matches no column and leaves data alone
  assign data_o     = odd_weight ? (rx_data ^ flip) : rx_data;
  assign syndrome_o = syndrome;

  // error class and a sanity check on the column match
  always_comb begin
    if (syndrome == '0) begin
      err_o = ERR_NONE;
    end else if (odd_weight) begin
      err_o = ERR_SINGLE;
    end else begin
      err_o = ERR_DOUBLE;
    end
    // distinct columns mean at most one data bit is ever flipped
    assert ($onehot0(flip) && (err_o != ecc_err_e'(2'b11)))
      else $error("decoder: flip=%h err=%h", flip, err_o);
  end

endmodule

`default_nettype wire

// ==== design/hci_ecc_bridge.sv ====
// HCI ECC bridge
`timescale 1ns/1ps
`default_nettype none

module hci_ecc_bridge #(
  parameter int unsigned UW = 4,
  parameter int unsigned AW = 6
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // initiator side
  input  logic                                  req_i,
  output logic                                  gnt_o,
  input  logic [AW-1:0]                         add_i,
  input  logic                                  wen_i,
  input  logic [ecc_mem_pkg::DATA_W-1:0]        data_i,
  input  logic [UW-1:0]                         user_i,
  output logic [ecc_mem_pkg::DATA_W-1:0]        r_data_o,
  output logic [UW-1:0]                         r_user_o,
  output logic                                  r_valid_o,
  output logic [ecc_mem_pkg::ECC_W-1:0]         syndrome_o,
  output ecc_mem_pkg::ecc_err_e                 err_o,
  // memory side, user widened by the check bits
  output logic                                  mem_req_o,
  input  logic                                  mem_gnt_i,
  output logic [AW-1:0]                         mem_add_o,
  output logic                                  mem_wen_o,
  output logic [ecc_mem_pkg::DATA_W-1:0]        mem_data_o,
  output logic [UW+ecc_mem_pkg::ECC_W-1:0]      mem_user_o,
  input  logic [ecc_mem_pkg::DATA_W-1:0]        mem_r_data_i,
  input  logic [UW+ecc_mem_pkg::ECC_W-1:0]      mem_r_user_i,
  input  logic                                  mem_r_valid_i
);

  import ecc_mem_pkg::*;

  localparam int unsigned USER_W = UW + ECC_W;

  logic [CODE_W-1:0] wr_code;
  logic [CODE_W-1:0] rd_code;
  logic              rd_pending_q;

  // handshake and address go straight across
  assign mem_req_o = req_i;
  assign gnt_o     = mem_gnt_i;
  assign mem_add_o = add_i;
  assign mem_wen_o = wen_i;
  assign r_valid_o = mem_r_valid_i;

  // write side, check bits sit above the user bits
  secded_39_32_enc i_enc (
    .data_i ( data_i  ),
    .code_o ( wr_code )
  );

  assign mem_data_o = wr_code[DATA_W-1:0];

  // read side, codeword rebuilt from upper user bits and data
  assign rd_code = {mem_r_user_i[USER_W-1:UW], mem_r_data_i};

  secded_39_32_dec i_dec (
    .code_i     ( rd_code    ),
    .data_o     ( r_data_o   ),
    .syndrome_o ( syndrome_o ),
    .err_o      ( err_o      )
  );

  if (UW > 0) begin : gen_user
    assign mem_user_o = {wr_code[CODE_W-1:DATA_W], user_i};
    assign r_user_o   = mem_r_user_i[UW-1:0];
  end else begin : gen_no_user
    assign mem_user_o = wr_code[CODE_W-1:DATA_W];
    assign r_user_o   = '0;
  end

  // remembers a read granted last cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= req_i & gnt_o & wen_i;
    end
  end

  // the bank answers every granted read one cycle on, and nothing else
  assert property (@(posedge clk_i) disable iff (rst_i) r_valid_o == rd_pending_q)
    else $error("bridge: r_valid=%b pending=%b", r_valid_o, rd_pending_q);

endmodule

`default_nettype wire

// ==== design/ecc_sram_bank.sv ====
// ECC SRAM bank
`timescale 1ns/1ps
`default_nettype none

module ecc_sram_bank #(
  parameter int unsigned UW = 4,
  parameter int unsigned AW = 6
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // target port
  input  logic                             req_i,
  output logic                             gnt_o,
  input  logic [AW-1:0]                    add_i,
  input  logic                             wen_i,
  input  logic [ecc_mem_pkg::DATA_W-1:0]   data_i,
  input  logic [UW+ecc_mem_pkg::ECC_W-1:0] user_i,
  // fault injection, xored into stored codeword
  input  logic [ecc_mem_pkg::CODE_W-1:0]   inject_mask_i,
  // read response
  output logic [ecc_mem_pkg::DATA_W-1:0]   r_data_o,
  output logic [UW+ecc_mem_pkg::ECC_W-1:0] r_user_o,
  output logic                             r_valid_o
);

  import ecc_mem_pkg::*;

  localparam int unsigned USER_W = UW + ECC_W;
  localparam int unsigned DEPTH  = 2 ** AW;

  logic [DATA_W-1:0] data_mem [DEPTH];
  logic [USER_W-1:0] user_mem [DEPTH];

  logic              wr_en;
  logic              rd_en;
  logic [USER_W-1:0] inj_user;
  logic [DATA_W-1:0] r_data_q;
  logic [USER_W-1:0] r_user_q;
  logic              r_valid_q;

  // no arbitration here, only reset holds off a request
  assign gnt_o = req_i & ~rst_i;

  // hci polarity, wen high is a read
  assign wr_en = req_i & gnt_o & ~wen_i;
  assign rd_en = req_i & gnt_o & wen_i;

  // the check part of the mask lines up with the top of the user field
  // the lower user bits are never disturbed
  assign inj_user = USER_W'(inject_mask_i[CODE_W-1:DATA_W]) << UW;

  // storage, full words only
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      data_mem[add_i] <= data_i ^ inject_mask_i[DATA_W-1:0];
      user_mem[add_i] <= user_i ^ inj_user;
    end
  end

  // read payload registered on the grant edge
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= data_mem[add_i];
      r_user_q <= user_mem[add_i];
    end
  end

  // one-cycle response strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;
    end
  end

  assign r_data_o  = r_data_q;
  assign r_user_o  = r_user_q;
  assign r_valid_o = r_valid_q;

  // an X address would corrupt or read an undefined word
  assert property (@(posedge clk_i) disable iff (rst_i) req_i |-> !$isunknown(add_i))
    else $error("bank: unknown add=%h with req", add_i);

endmodule

`default_nettype wire

// ==== design/ecc_mem_top.sv ====
// ECC memory top level
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top #(
  parameter int unsigned UW = 4,
  parameter int unsigned AW = 6
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // initiator port
  input  logic                           req_i,
  output logic                           gnt_o,
  input  logic [AW-1:0]                  add_i,
  input  logic                           wen_i,
  input  logic [ecc_mem_pkg::DATA_W-1:0] data_i,
  input  logic [UW-1:0]                  user_i,
  output logic [ecc_mem_pkg::DATA_W-1:0] r_data_o,
  output logic [UW-1:0]                  r_user_o,
  output logic                           r_valid_o,
  output logic [ecc_mem_pkg::ECC_W-1:0]  syndrome_o,
  output ecc_mem_pkg::ecc_err_e          err_o,
  // fault injection into the bank
  input  logic [ecc_mem_pkg::CODE_W-1:0] inject_mask_i
);

  import ecc_mem_pkg::*;

  // bridge to bank
  logic                 mem_req;
  logic                 mem_gnt;
  logic [AW-1:0]        mem_add;
  logic                 mem_wen;
  logic [DATA_W-1:0]    mem_data;
  logic [UW+ECC_W-1:0]  mem_user;
  logic [DATA_W-1:0]    mem_r_data;
  logic [UW+ECC_W-1:0]  mem_r_user;
  logic                 mem_r_valid;

  hci_ecc_bridge #(
    .UW ( UW ),
    .AW ( AW )
  ) i_bridge (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .req_i         ( req_i       ),
    .gnt_o         ( gnt_o       ),
    .add_i         ( add_i       ),
    .wen_i         ( wen_i       ),
    .data_i        ( data_i      ),
    .user_i        ( user_i      ),
    .r_data_o      ( r_data_o    ),
    .r_user_o      ( r_user_o    ),
    .r_valid_o     ( r_valid_o   ),
    .syndrome_o    ( syndrome_o  ),
    .err_o         ( err_o       ),
    .mem_req_o     ( mem_req     ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_add_o     ( mem_add     ),
    .mem_wen_o     ( mem_wen     ),
    .mem_data_o    ( mem_data    ),
    .mem_user_o    ( mem_user    ),
    .mem_r_data_i  ( mem_r_data  ),
    .mem_r_user_i  ( mem_r_user  ),
    .mem_r_valid_i ( mem_r_valid )
  );

  ecc_sram_bank #(
    .UW ( UW ),
    .AW ( AW )
  ) i_bank (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .req_i         ( mem_req       ),
    .gnt_o         ( mem_gnt       ),
    .add_i         ( mem_add       ),
    .wen_i         ( mem_wen       ),
    .data_i        ( mem_data      ),
    .user_i        ( mem_user      ),
    .inject_mask_i ( inject_mask_i ),
    .r_data_o      ( mem_r_data    ),
    .r_user_o      ( mem_r_user    ),
    .r_valid_o     ( mem_r_valid   )
  );

endmodule

`default_nettype wire

// ==== sim/tb_ecc_mem.sv ====
// ECC memory testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_mem;

  import ecc_mem_pkg::*;

  localparam int unsigned UW      = 4;
  localparam int unsigned AW      = 6;
  localparam int unsigned TIMEOUT = 100;

  logic              clk_i;
  logic              rst_i;
  logic              req_i;
  logic              gnt_o;
  logic [AW-1:0]     add_i;
  logic              wen_i;
  logic [DATA_W-1:0] data_i;
  logic [UW-1:0]     user_i;
  logic [DATA_W-1:0] r_data_o;
  logic [UW-1:0]     r_user_o;
  logic              r_valid_o;
  logic [ECC_W-1:0]  syndrome_o;
  ecc_err_e          err_o;
  logic [CODE_W-1:0] inject_mask_i;

  // reference model, one entry per word address
  logic [DATA_W-1:0] model_data  [2**AW];
  logic [UW-1:0]     model_user  [2**AW];
  ecc_err_e          model_class [2**AW];

  // expectation for the response in flight
  logic [DATA_W-1:0] exp_data  = '0;
  logic [UW-1:0]     exp_user  = '0;
  ecc_err_e          exp_class = ERR_NONE;
  logic              rd_q      = 1'b0;
  logic              rst_q     = 1'b0;

  integer seed = 32'h56d4621d;
  int     errors = 0;
  int     err_mark = 0;
  int     tests = 0;
  int     responses = 0;
  int     reads_issued = 0;

  ecc_mem_top #(
    .UW ( UW ),
    .AW ( AW )
  ) dut_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .req_i         ( req_i         ),
    .gnt_o         ( gnt_o         ),
    .add_i         ( add_i         ),
    .wen_i         ( wen_i         ),
    .data_i        ( data_i        ),
    .user_i        ( user_i        ),
    .r_data_o      ( r_data_o      ),
    .r_user_o      ( r_user_o      ),
    .r_valid_o     ( r_valid_o     ),
    .syndrome_o    ( syndrome_o    ),
    .err_o         ( err_o         ),
    .inject_mask_i ( inject_mask_i )
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // the stored word keeps its data as long as at most one bit was hit
  function automatic ecc_err_e class_of_mask(input logic [CODE_W-1:0] mask);
    int unsigned ones;
    ones = 0;
    for (int unsigned i = 0; i < CODE_W; i++) begin
      if (mask[i]) ones++;
    end
    if (ones == 0) return ERR_NONE;
    else if (ones == 1) return ERR_SINGLE;
    else return ERR_DOUBLE;
  endfunction

  function automatic int unsigned rand_below(input int unsigned span);
    return $unsigned($random(seed)) % span;
  endfunction

  // model follows every granted transfer
  always @(posedge clk_i) begin
    rst_q <= rst_i;
    rd_q  <= !rst_i && req_i && gnt_o && wen_i;
    if (!rst_i && req_i && gnt_o && !wen_i) begin
      // a double error comes back uncorrected, a single one is repaired
      if (class_of_mask(inject_mask_i) == ERR_DOUBLE) begin
        model_data[add_i] <= data_i ^ inject_mask_i[DATA_W-1:0];
      end else begin
        model_data[add_i] <= data_i;
      end
      model_user[add_i]  <= user_i;
      model_class[add_i] <= class_of_mask(inject_mask_i);
    end
    if (!rst_i && req_i && gnt_o && wen_i) begin
      exp_data  <= model_data[add_i];
      exp_user  <= model_user[add_i];
      exp_class <= model_class[add_i];
    end
    if (r_valid_o) responses <= responses + 1;
  end

  a_rst_gnt: assert property (@(posedge clk_i) rst_i |-> !gnt_o)
    else begin
      errors++;
      $display("[ERROR] gnt_o got %h expected 0 in reset", $sampled(gnt_o));
    end

  // covers the reset cycles and the first cycle after release
  a_rst_valid: assert property (@(posedge clk_i) rst_q |-> !r_valid_o)
    else begin
      errors++;
      $display("[ERROR] r_valid_o got %h expected 0 around reset", $sampled(r_valid_o));
    end

  a_gnt: assert property (@(posedge clk_i) (!rst_i && req_i) |-> gnt_o)
    else begin
      errors++;
      $display("[ERROR] gnt_o got %h expected 1 with req_i", $sampled(gnt_o));
    end

  // exactly one cycle from granted read to response
  a_latency: assert property (@(posedge clk_i) disable iff (rst_i) r_valid_o == rd_q)
    else begin
      errors++;
      $display("[ERROR] r_valid_o got %h expected %h", $sampled(r_valid_o), $sampled(rd_q));
    end

  // every response carries the modelled data, corrected or not
  a_data: assert property (@(posedge clk_i) !r_valid_o || r_data_o == exp_data)
    else begin
      errors++;
      $display("[ERROR] r_data_o got %h expected %h", $sampled(r_data_o), $sampled(exp_data));
    end

  a_user: assert property (@(posedge clk_i) !r_valid_o || r_user_o == exp_user)
    else begin
      errors++;
      $display("[ERROR] r_user_o got %h expected %h", $sampled(r_user_o), $sampled(exp_user));
    end

  a_class: assert property (@(posedge clk_i) !r_valid_o || err_o == exp_class)
    else begin
      errors++;
      $display("[ERROR] err_o got %h expected %h", $sampled(err_o), $sampled(exp_class));
    end

  // zero syndrome exactly when nothing was injected
  a_synd: assert property (@(posedge clk_i)
      !r_valid_o || ((syndrome_o == '0) == (exp_class == ERR_NONE)))
    else begin
      errors++;
      $display("[ERROR] syndrome_o got %h with err class %h",
               $sampled(syndrome_o), $sampled(exp_class));
    end

  task automatic abort_run(input string what);
    $display("timeout: %s after %0d cycles", what, TIMEOUT);
    $display("Checks failed");
    $finish;
  endtask

  // returns on the edge where the request was granted
  task automatic wait_grant();
    int unsigned n;
    n = 0;
    @(posedge clk_i);
    while (!gnt_o && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (!gnt_o) abort_run("request never granted");
  endtask

  task automatic write_word(input logic [AW-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [UW-1:0] user, input logic [CODE_W-1:0] mask);
    req_i         <= 1'b1;
    wen_i         <= 1'b0;
    add_i         <= addr;
    data_i        <= data;
    user_i        <= user;
    inject_mask_i <= mask;
    wait_grant();
  endtask

  // hci read, wen high
  task automatic read_word(input logic [AW-1:0] addr);
    req_i         <= 1'b1;
    wen_i         <= 1'b1;
    add_i         <= addr;
    inject_mask_i <= '0;
    wait_grant();
    reads_issued++;
  endtask

  // drop the request and wait out every pending response
  task automatic drain();
    int unsigned n;
    n = 0;
    req_i <= 1'b0;
    while (responses != reads_issued && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (responses != reads_issued) abort_run("read response missing");
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-12s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // eight clean words, then read back to back
  task automatic clean_test();
    logic [AW-1:0] addrs [8];
    for (int k = 0; k < 8; k++) begin
      addrs[k] = AW'($random(seed));
      write_word(addrs[k], $random(seed), UW'($random(seed)), '0);
    end
    for (int k = 0; k < 8; k++) read_word(addrs[k]);
    drain();
  endtask

  // one flipped bit somewhere in [lo, lo+span)
  task automatic flip_test(input int unsigned lo, input int unsigned span);
    logic [AW-1:0] addr;
    for (int k = 0; k < 6; k++) begin
      addr = AW'($random(seed));
      write_word(addr, $random(seed), UW'($random(seed)),
                 CODE_W'(1) << (lo + rand_below(span)));
      read_word(addr);
    end
    drain();
  endtask

  task automatic double_test();
    logic [AW-1:0] addr;
    int unsigned   p1;
    int unsigned   p2;
    for (int k = 0; k < 6; k++) begin
      addr = AW'($random(seed));
      p1   = rand_below(CODE_W);
      // second position always differs from the first
      p2   = (p1 + 1 + rand_below(CODE_W - 1)) % CODE_W;
      write_word(addr, $random(seed), UW'($random(seed)),
                 (CODE_W'(1) << p1) | (CODE_W'(1) << p2));
      read_word(addr);
    end
    drain();
  endtask

  // user bits ride through damage, a clean rewrite heals the word
  task automatic user_test();
    logic [AW-1:0] addr;
    addr = AW'($random(seed));
    write_word(addr, $random(seed), '1, (CODE_W'(1) << 35) | (CODE_W'(1) << 3));
    read_word(addr);
    write_word(addr, $random(seed), UW'(4'h5), CODE_W'(1) << 38);
    read_word(addr);
    write_word(addr, $random(seed), UW'(4'ha), '0);
    read_word(addr);
    drain();
  endtask

  initial begin
    rst_i         = 1'b1;
    req_i         = 1'b0;
    add_i         = '0;
    wen_i         = 1'b1;
    data_i        = '0;
    user_i        = '0;
    inject_mask_i = '0;

    // a read held during reset must not be granted
    @(posedge clk_i);
    req_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    req_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    end_test("reset_state");

    clean_test();
    end_test("clean_rw");
    flip_test(0, DATA_W);
    end_test("data_flip");
    flip_test(DATA_W, ECC_W);
    end_test("check_flip");
    double_test();
    end_test("double_flip");
    user_test();
    end_test("user_rewrite");

    $display("tests %0d, responses %0d, errors %0d", tests, responses, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ecc_mem.f ====
design/ecc_mem_pkg.sv
design/secded_39_32_enc.sv
design/secded_39_32_dec.sv
design/hci_ecc_bridge.sv
design/ecc_sram_bank.sv
design/ecc_mem_top.sv
sim/tb_ecc_mem.sv

// ==== Makefile ====
# Verilator build and run for the ECC memory testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_mem
FILELIST  ?= ecc_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, since tee hides the simulator exit status
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
